/* source/camera_pkg.sv */
/*
 * Shared widths and enums for the exposure-metering path.
 * Raw samples are 10-bit Bayer. Metering keeps only the top 8 bits.
 * Opcode values are fixed by the host protocol and must not move.
 */

`default_nettype none

package camera_pkg;

    localparam int PIXEL_BITS = 10; // Raw Bayer sample
    localparam int METER_BITS = 8;  // Metering result

    typedef enum logic [1:0] {
        IDLE,
        ACCUMULATE,
        REPORT
    } metering_state_t;

    typedef enum logic [7:0] {
        OP_RED_CENTER    = 8'h10,
        OP_GREEN_CENTER  = 8'h11,
        OP_BLUE_CENTER   = 8'h12,
        OP_RED_AVERAGE   = 8'h13,
        OP_GREEN_AVERAGE = 8'h14,
        OP_BLUE_AVERAGE  = 8'h15,
        OP_STATUS        = 8'h20, // Bit 1 average latched, bit 0 centre latched
        OP_FRAME_COUNT   = 8'h21  // Modulo 256
    } camera_opcode_t;

endpackage

`default_nettype wire

/* source/bayer_crop.sv */
/*
 * Fixed crop window on a raw Bayer stream, 1 cycle latency.
 * WIDTH and HEIGHT must be even so each output row starts on a full quad.
 * Counters saturate at the window end, so raw frames may be any size.
 */

`timescale 1ns/1ns
`default_nettype none

module bayer_crop #(
    parameter int X_START = 0,
    parameter int Y_START = 0,
    parameter int WIDTH   = 16,
    parameter int HEIGHT  = 16
) (
    input  logic                              mipi_byte_clock,
    input  logic                              mipi_byte_reset_n,
    input  logic [camera_pkg::PIXEL_BITS-1:0] bayer_data_i,
    input  logic                              line_valid_i,
    input  logic                              frame_valid_i,
    output logic [camera_pkg::PIXEL_BITS-1:0] bayer_data_o,
    output logic                              line_valid_o,
    output logic                              frame_valid_o
);

    import camera_pkg::*;

    localparam int X_BITS = $clog2(X_START + WIDTH + 1);
    localparam int Y_BITS = $clog2(Y_START + HEIGHT + 1);
    localparam logic [X_BITS-1:0] X_FIRST = X_BITS'(X_START);
    localparam logic [X_BITS-1:0] X_LIMIT = X_BITS'(X_START + WIDTH);
    localparam logic [Y_BITS-1:0] Y_FIRST = Y_BITS'(Y_START);
    localparam logic [Y_BITS-1:0] Y_LIMIT = Y_BITS'(Y_START + HEIGHT);

    logic [X_BITS-1:0] column;
    logic [Y_BITS-1:0] row;
    logic              line_valid_q;
    logic              pixel;
    logic              in_window;

    assign pixel = line_valid_i && frame_valid_i;
    assign in_window = pixel && column >= X_FIRST && column < X_LIMIT &&
                       row >= Y_FIRST && row < Y_LIMIT;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            column <= '0;
            row <= '0;
            line_valid_q <= 1'b0;
            line_valid_o <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            line_valid_q <= line_valid_i;
            line_valid_o <= in_window;
            frame_valid_o <= frame_valid_i;

            if (!line_valid_i)
                column <= '0; // Restart at each line
            else if (pixel && column != X_LIMIT)
                column <= column + 1'b1;

            if (!frame_valid_i)
                row <= '0;
            else if (line_valid_q && !line_valid_i && row != Y_LIMIT)
                row <= row + 1'b1; // Falling line valid
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        bayer_data_o <= bayer_data_i;
    end

endmodule

`default_nettype wire

/* source/debayer.sv */
/*
 * Half-resolution debayer for an RGGB stream, one RGB pixel per 2x2 quad.
 * Each cropped row must hold exactly WIDTH pixels and start on an R sample.
 * Even rows go to the line buffer; odd rows complete the quads.
 * Output comes 1 cycle after the B sample of each quad.
 */

`timescale 1ns/1ns
`default_nettype none

module debayer #(
    parameter int WIDTH = 16
) (
    input  logic                              mipi_byte_clock,
    input  logic                              mipi_byte_reset_n,
    input  logic [camera_pkg::PIXEL_BITS-1:0] bayer_data_i,
    input  logic                              line_valid_i,
    input  logic                              frame_valid_i,
    output logic [camera_pkg::PIXEL_BITS-1:0] red_o,
    output logic [camera_pkg::PIXEL_BITS-1:0] green_o,
    output logic [camera_pkg::PIXEL_BITS-1:0] blue_o,
    output logic                              rgb_valid_o,
    output logic                              frame_valid_o
);

    import camera_pkg::*;

    localparam int COL_BITS = $clog2(WIDTH);

    logic [PIXEL_BITS-1:0] line_buffer [WIDTH];
    logic [PIXEL_BITS-1:0] previous;
    logic [PIXEL_BITS:0]   green_sum;
    logic [COL_BITS-1:0]   column;
    logic [COL_BITS-1:0]   red_column;
    logic                  odd_row;
    logic                  line_valid_q;
    logic                  pixel;
    logic                  quad_done;

    assign pixel = line_valid_i && frame_valid_i;
    assign quad_done = pixel && odd_row && column[0];
    assign red_column = {column[COL_BITS-1:1], 1'b0};

    // G above plus G to the left
    assign green_sum = {1'b0, line_buffer[column]} + {1'b0, previous};

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            column <= '0;
            odd_row <= 1'b0;
            line_valid_q <= 1'b0;
            rgb_valid_o <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            line_valid_q <= line_valid_i;
            rgb_valid_o <= quad_done;
            frame_valid_o <= frame_valid_i;

            if (!line_valid_i)
                column <= '0;
            else if (pixel)
                column <= column + 1'b1;

            if (!frame_valid_i)
                odd_row <= 1'b0;
            else if (line_valid_q && !line_valid_i)
                odd_row <= !odd_row; // Row parity flips per line
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (pixel && !odd_row)
            line_buffer[column] <= bayer_data_i; // R G R G row

        if (pixel)
            previous <= bayer_data_i;

        if (quad_done) begin
            red_o <= line_buffer[red_column];
            green_o <= green_sum[PIXEL_BITS:1];
            blue_o <= bayer_data_i;
        end
    end

    // Every row fills the line buffer exactly
    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        line_valid_q && !line_valid_i |-> column == COL_BITS'(WIDTH));

endmodule

`default_nettype wire

/* source/metering.sv */
/*
 * Per-frame average of the top 8 bits of each colour over a centred
 * WINDOW_SIZE square. WINDOW_SIZE must be a power of two and fit the image.
 * Results update and ready pulses 1 cycle after frame valid falls.
 */

`timescale 1ns/1ns
`default_nettype none

module metering #(
    parameter int IMAGE_WIDTH  = 8,
    parameter int IMAGE_HEIGHT = 8,
    parameter int WINDOW_SIZE  = 4
) (
    input  logic                              mipi_byte_clock,
    input  logic                              mipi_byte_reset_n,
    input  logic [camera_pkg::PIXEL_BITS-1:0] red_i,
    input  logic [camera_pkg::PIXEL_BITS-1:0] green_i,
    input  logic [camera_pkg::PIXEL_BITS-1:0] blue_i,
    input  logic                              rgb_valid_i,
    input  logic                              frame_valid_i,
    output logic [camera_pkg::METER_BITS-1:0] red_o,
    output logic [camera_pkg::METER_BITS-1:0] green_o,
    output logic [camera_pkg::METER_BITS-1:0] blue_o,
    output logic                              metering_ready_o
);

    import camera_pkg::*;

    localparam int SHIFT    = 2 * $clog2(WINDOW_SIZE);
    localparam int SUM_BITS = METER_BITS + SHIFT;
    localparam int X_BITS   = $clog2(IMAGE_WIDTH + 1);
    localparam int Y_BITS   = $clog2(IMAGE_HEIGHT + 1);
    localparam logic [X_BITS-1:0] X_LAST  = X_BITS'(IMAGE_WIDTH - 1);
    localparam logic [X_BITS-1:0] X_FIRST = X_BITS'((IMAGE_WIDTH - WINDOW_SIZE) / 2);
    localparam logic [X_BITS-1:0] X_LIMIT = X_BITS'((IMAGE_WIDTH + WINDOW_SIZE) / 2);
    localparam logic [Y_BITS-1:0] Y_FIRST = Y_BITS'((IMAGE_HEIGHT - WINDOW_SIZE) / 2);
    localparam logic [Y_BITS-1:0] Y_LIMIT = Y_BITS'((IMAGE_HEIGHT + WINDOW_SIZE) / 2);

    metering_state_t     state;
    logic [X_BITS-1:0]   x;
    logic [Y_BITS-1:0]   y;
    logic [SUM_BITS-1:0] red_sum;
    logic [SUM_BITS-1:0] green_sum;
    logic [SUM_BITS-1:0] blue_sum;
    logic                frame_valid_q;
    logic                frame_rise;
    logic                frame_fall;
    logic                in_window;

    assign frame_rise = frame_valid_i && !frame_valid_q;
    assign frame_fall = !frame_valid_i && frame_valid_q;
    assign in_window = x >= X_FIRST && x < X_LIMIT && y >= Y_FIRST && y < Y_LIMIT;
    assign metering_ready_o = state == REPORT;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state <= IDLE;
            frame_valid_q <= 1'b0;
            x <= '0;
            y <= '0;
            red_sum <= '0;
            green_sum <= '0;
            blue_sum <= '0;
            red_o <= '0;
            green_o <= '0;
            blue_o <= '0;
        end else begin
            frame_valid_q <= frame_valid_i;

            case (state)
                IDLE, REPORT: begin
                    state <= IDLE;
                    if (frame_rise) begin // New frame clears everything
                        state <= ACCUMULATE;
                        x <= '0;
                        y <= '0;
                        red_sum <= '0;
                        green_sum <= '0;
                        blue_sum <= '0;
                    end
                end

                ACCUMULATE: begin
                    if (frame_fall) begin
                        state <= REPORT;
                        red_o <= red_sum[SHIFT +: METER_BITS]; // Divide by window area
                        green_o <= green_sum[SHIFT +: METER_BITS];
                        blue_o <= blue_sum[SHIFT +: METER_BITS];
                    end else if (rgb_valid_i) begin
                        if (in_window) begin
                            red_sum <= red_sum + SUM_BITS'(red_i[PIXEL_BITS-1 -: METER_BITS]);
                            green_sum <= green_sum + SUM_BITS'(green_i[PIXEL_BITS-1 -: METER_BITS]);
                            blue_sum <= blue_sum + SUM_BITS'(blue_i[PIXEL_BITS-1 -: METER_BITS]);
                        end
                        if (x == X_LAST) begin
                            x <= '0;
                            y <= y + 1'b1;
                        end else begin
                            x <= x + 1'b1;
                        end
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // A whole image arrived before the report
    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        metering_ready_o |-> x == '0 && y == Y_BITS'(IMAGE_HEIGHT));

endmodule

`default_nettype wire

/* source/metering_registers.sv */
/*
 * Result latches and opcode read port for the two metering blocks.
 * Every request gets exactly one response 1 cycle later.
 * Unknown opcodes read as 0. Frame count wraps at 256.
 */

`timescale 1ns/1ns
`default_nettype none

module metering_registers (
    input  logic                              mipi_byte_clock,
    input  logic                              mipi_byte_reset_n,
    input  logic [camera_pkg::METER_BITS-1:0] center_red_i,
    input  logic [camera_pkg::METER_BITS-1:0] center_green_i,
    input  logic [camera_pkg::METER_BITS-1:0] center_blue_i,
    input  logic [camera_pkg::METER_BITS-1:0] average_red_i,
    input  logic [camera_pkg::METER_BITS-1:0] average_green_i,
    input  logic [camera_pkg::METER_BITS-1:0] average_blue_i,
    input  logic                              center_ready_i,
    input  logic                              average_ready_i,
    input  logic [7:0]                        op_code_i,
    input  logic                              op_code_valid_i,
    output logic [7:0]                        response_o,
    output logic                              response_valid_o
);

    import camera_pkg::*;

    logic [METER_BITS-1:0] center_red;
    logic [METER_BITS-1:0] center_green;
    logic [METER_BITS-1:0] center_blue;
    logic [METER_BITS-1:0] average_red;
    logic [METER_BITS-1:0] average_green;
    logic [METER_BITS-1:0] average_blue;
    logic                  center_latched;
    logic                  average_latched;
    logic [7:0]            frame_count;
    logic [7:0]            read_value;

    always_comb begin
        case (camera_opcode_t'(op_code_i))
            OP_RED_CENTER:    read_value = center_red;
            OP_GREEN_CENTER:  read_value = center_green;
            OP_BLUE_CENTER:   read_value = center_blue;
            OP_RED_AVERAGE:   read_value = average_red;
            OP_GREEN_AVERAGE: read_value = average_green;
            OP_BLUE_AVERAGE:  read_value = average_blue;
            OP_STATUS:        read_value = {6'd0, average_latched, center_latched};
            OP_FRAME_COUNT:   read_value = frame_count;
            default:          read_value = 8'd0;
        endcase
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            center_red <= '0;
            center_green <= '0;
            center_blue <= '0;
            average_red <= '0;
            average_green <= '0;
            average_blue <= '0;
            center_latched <= 1'b0;
            average_latched <= 1'b0;
            frame_count <= '0;
            response_o <= '0;
            response_valid_o <= 1'b0;
        end else begin
            if (center_ready_i) begin
                center_red <= center_red_i;
                center_green <= center_green_i;
                center_blue <= center_blue_i;
                center_latched <= 1'b1;
                frame_count <= frame_count + 1'b1; // One per completed frame
            end

            if (average_ready_i) begin
                average_red <= average_red_i;
                average_green <= average_green_i;
                average_blue <= average_blue_i;
                average_latched <= 1'b1;
            end

            response_valid_o <= op_code_valid_i;
            if (op_code_valid_i)
                response_o <= read_value;
        end
    end

    // Both metering blocks see the same frame, so they report together
    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        center_ready_i == average_ready_i);

endmodule

`default_nettype wire

/* source/camera_pipeline.sv */
/*
 * Exposure-metering path on the MIPI byte clock.
 * Crop size must be even; each metering window a power of two no larger
 * than the debayered image of CROP_WIDTH/2 by CROP_HEIGHT/2.
 * The stream never stalls, so there is no back-pressure anywhere.
 */

`timescale 1ns/1ns
`default_nettype none

module camera_pipeline #(
    parameter int CROP_X_START   = 2,
    parameter int CROP_Y_START   = 1,
    parameter int CROP_WIDTH     = 16,
    parameter int CROP_HEIGHT    = 16,
    parameter int CENTER_WINDOW  = 4,
    parameter int AVERAGE_WINDOW = 8
) (
    input  logic                              mipi_byte_clock,
    input  logic                              mipi_byte_reset_n,
    input  logic [camera_pkg::PIXEL_BITS-1:0] bayer_data_i,
    input  logic                              line_valid_i,
    input  logic                              frame_valid_i,
    input  logic [7:0]                        op_code_i,
    input  logic                              op_code_valid_i,
    output logic [7:0]                        response_o,
    output logic                              response_valid_o
);

    import camera_pkg::*;

    logic [PIXEL_BITS-1:0] cropped_data;
    logic                  cropped_line_valid;
    logic                  cropped_frame_valid;

    logic [PIXEL_BITS-1:0] rgb_red;
    logic [PIXEL_BITS-1:0] rgb_green;
    logic [PIXEL_BITS-1:0] rgb_blue;
    logic                  rgb_valid;
    logic                  rgb_frame_valid;

    logic [METER_BITS-1:0] center_red;
    logic [METER_BITS-1:0] center_green;
    logic [METER_BITS-1:0] center_blue;
    logic                  center_ready;
    logic [METER_BITS-1:0] average_red;
    logic [METER_BITS-1:0] average_green;
    logic [METER_BITS-1:0] average_blue;
    logic                  average_ready;

    bayer_crop #(
        .X_START(CROP_X_START),
        .Y_START(CROP_Y_START),
        .WIDTH  (CROP_WIDTH),
        .HEIGHT (CROP_HEIGHT)
    ) i_bayer_crop (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .bayer_data_i     (bayer_data_i),
        .line_valid_i     (line_valid_i),
        .frame_valid_i    (frame_valid_i),
        .bayer_data_o     (cropped_data),
        .line_valid_o     (cropped_line_valid),
        .frame_valid_o    (cropped_frame_valid)
    );

    debayer #(
        .WIDTH(CROP_WIDTH)
    ) i_debayer (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .bayer_data_i     (cropped_data),
        .line_valid_i     (cropped_line_valid),
        .frame_valid_i    (cropped_frame_valid),
        .red_o            (rgb_red),
        .green_o          (rgb_green),
        .blue_o           (rgb_blue),
        .rgb_valid_o      (rgb_valid),
        .frame_valid_o    (rgb_frame_valid)
    );

    metering #(
        .IMAGE_WIDTH (CROP_WIDTH / 2),
        .IMAGE_HEIGHT(CROP_HEIGHT / 2),
        .WINDOW_SIZE (CENTER_WINDOW)
    ) center_metering (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .red_i            (rgb_red),
        .green_i          (rgb_green),
        .blue_i           (rgb_blue),
        .rgb_valid_i      (rgb_valid),
        .frame_valid_i    (rgb_frame_valid),
        .red_o            (center_red),
        .green_o          (center_green),
        .blue_o           (center_blue),
        .metering_ready_o (center_ready)
    );

    metering #(
        .IMAGE_WIDTH (CROP_WIDTH / 2),
        .IMAGE_HEIGHT(CROP_HEIGHT / 2),
        .WINDOW_SIZE (AVERAGE_WINDOW)
    ) average_metering (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .red_i            (rgb_red),
        .green_i          (rgb_green),
        .blue_i           (rgb_blue),
        .rgb_valid_i      (rgb_valid),
        .frame_valid_i    (rgb_frame_valid),
        .red_o            (average_red),
        .green_o          (average_green),
        .blue_o           (average_blue),
        .metering_ready_o (average_ready)
    );

    metering_registers i_metering_registers (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .center_red_i     (center_red),
        .center_green_i   (center_green),
        .center_blue_i    (center_blue),
        .average_red_i    (average_red),
        .average_green_i  (average_green),
        .average_blue_i   (average_blue),
        .center_ready_i   (center_ready),
        .average_ready_i  (average_ready),
        .op_code_i        (op_code_i),
        .op_code_valid_i  (op_code_valid_i),
        .response_o       (response_o),
        .response_valid_o (response_valid_o)
    );

endmodule

`default_nettype wire

/* dv/camera_pipeline_tb.sv */
/*
 * Testbench for camera_pipeline with 20x18 raw frames and a 16x16 crop at (2,1).
 * The debayered image is 8x8; centre window 4 and average window 8.
 * Each table entry drives one frame and waits 4 cycles after frame valid
 * falls. It then reads a list of opcodes and checks them against a frame model.
 */

`timescale 1ns/1ns
`default_nettype none

module camera_pipeline_tb;

    import camera_pkg::*;

    localparam int RAW_WIDTH       = 20;
    localparam int RAW_HEIGHT      = 18;
    localparam int LINE_GAP        = 3;
    localparam int FRAME_LEAD      = 2;
    localparam int CROP_X          = 2;
    localparam int CROP_Y          = 1;
    localparam int CROP_SIZE       = 16;
    localparam int IMAGE_SIZE      = CROP_SIZE / 2;
    localparam int CENTER_WINDOW   = 4;
    localparam int AVERAGE_WINDOW  = 8;
    localparam int NUM_ENTRIES     = 5;
    localparam int FRAME_CYCLES    = FRAME_LEAD + RAW_HEIGHT * (RAW_WIDTH + LINE_GAP) + 1;
    localparam int WATCHDOG_CYCLES = (NUM_ENTRIES + 1) * (FRAME_CYCLES + 50); // One extra for reset

    // Opcodes are read from the low byte up
    localparam logic [63:0] ALL_READS = {OP_FRAME_COUNT, OP_STATUS, OP_BLUE_AVERAGE,
        OP_GREEN_AVERAGE, OP_RED_AVERAGE, OP_BLUE_CENTER, OP_GREEN_CENTER, OP_RED_CENTER};
    localparam logic [63:0] RESULT_READS = {16'h0000, OP_BLUE_AVERAGE, OP_GREEN_AVERAGE,
        OP_RED_AVERAGE, OP_BLUE_CENTER, OP_GREEN_CENTER, OP_RED_CENTER};
    localparam logic [63:0] ODD_READS = {OP_FRAME_COUNT, OP_STATUS, 8'h33, 8'hff,
        OP_BLUE_AVERAGE, OP_GREEN_CENTER, OP_RED_AVERAGE, OP_RED_CENTER};

    typedef struct packed {
        logic        use_lcg;  // Pseudo-random pixels everywhere
        logic [9:0]  red;
        logic [9:0]  green;
        logic [9:0]  blue;
        logic [9:0]  border;   // Outside the crop window
        logic [3:0]  op_count;
        logic [63:0] ops;
    } test_entry_t;

    logic              mipi_byte_clock;
    logic              mipi_byte_reset_n;
    logic [9:0]        bayer_data;
    logic              line_valid;
    logic              frame_valid;
    logic [7:0]        op_code;
    logic              op_code_valid;
    logic [7:0]        response;
    logic              response_valid;

    test_entry_t       tests [NUM_ENTRIES];
    logic [9:0]        frame_pixels [RAW_HEIGHT][RAW_WIDTH];
    logic [7:0]        center_model [3];
    logic [7:0]        average_model [3];
    logic [31:0]       lcg_state;
    int                frames_done;
    int                requests;
    int                pulses;
    int                checks;
    int                errors;

    camera_pipeline #(
        .CROP_X_START  (CROP_X),
        .CROP_Y_START  (CROP_Y),
        .CROP_WIDTH    (CROP_SIZE),
        .CROP_HEIGHT   (CROP_SIZE),
        .CENTER_WINDOW (CENTER_WINDOW),
        .AVERAGE_WINDOW(AVERAGE_WINDOW)
    ) i_dut (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .bayer_data_i     (bayer_data),
        .line_valid_i     (line_valid),
        .frame_valid_i    (frame_valid),
        .op_code_i        (op_code),
        .op_code_valid_i  (op_code_valid),
        .response_o       (response),
        .response_valid_o (response_valid)
    );

    always #2 mipi_byte_clock = ~mipi_byte_clock;

    always @(negedge mipi_byte_clock) begin
        if (response_valid)
            pulses <= pulses + 1; // Every cycle of every response
    end

    function automatic logic [9:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[25:16];
    endfunction

    function automatic logic [7:0] expected_response(input logic [7:0] op);
        case (op)
            OP_RED_CENTER:    return center_model[0];
            OP_GREEN_CENTER:  return center_model[1];
            OP_BLUE_CENTER:   return center_model[2];
            OP_RED_AVERAGE:   return average_model[0];
            OP_GREEN_AVERAGE: return average_model[1];
            OP_BLUE_AVERAGE:  return average_model[2];
            OP_STATUS:        return (frames_done > 0) ? 8'd3 : 8'd0;
            OP_FRAME_COUNT:   return 8'(frames_done);
            default:          return 8'd0;
        endcase
    endfunction

    task automatic build_frame(input test_entry_t entry);
        int cy;
        int cx;
        for (int y = 0; y < RAW_HEIGHT; y++) begin
            for (int x = 0; x < RAW_WIDTH; x++) begin
                cy = y - CROP_Y;
                cx = x - CROP_X;
                if (entry.use_lcg)
                    frame_pixels[y][x] = lcg_next();
                else if (cy < 0 || cy >= CROP_SIZE || cx < 0 || cx >= CROP_SIZE)
                    frame_pixels[y][x] = entry.border;
                else if (cy % 2 == 0 && cx % 2 == 0)
                    frame_pixels[y][x] = entry.red;
                else if (cy % 2 == 1 && cx % 2 == 1)
                    frame_pixels[y][x] = entry.blue;
                else
                    frame_pixels[y][x] = entry.green;
            end
        end
    endtask

    // Quad decode and both windows on the top 8 bits of each colour
    task automatic compute_model();
        int center_sum [3];
        int average_sum [3];
        int colour [3];
        int row;
        int col;
        int center_first;
        int average_first;
        center_first = (IMAGE_SIZE - CENTER_WINDOW) / 2;
        average_first = (IMAGE_SIZE - AVERAGE_WINDOW) / 2;
        for (int c = 0; c < 3; c++) begin
            center_sum[c] = 0;
            average_sum[c] = 0;
        end
        for (int qy = 0; qy < IMAGE_SIZE; qy++) begin
            for (int qx = 0; qx < IMAGE_SIZE; qx++) begin
                row = CROP_Y + 2 * qy;
                col = CROP_X + 2 * qx;
                colour[0] = int'(frame_pixels[row][col]) >> 2;
                colour[1] = ((int'(frame_pixels[row][col + 1]) +
                              int'(frame_pixels[row + 1][col])) >> 1) >> 2;
                colour[2] = int'(frame_pixels[row + 1][col + 1]) >> 2;
                for (int c = 0; c < 3; c++) begin
                    if (qx >= center_first && qx < center_first + CENTER_WINDOW &&
                        qy >= center_first && qy < center_first + CENTER_WINDOW)
                        center_sum[c] += colour[c];
                    if (qx >= average_first && qx < average_first + AVERAGE_WINDOW &&
                        qy >= average_first && qy < average_first + AVERAGE_WINDOW)
                        average_sum[c] += colour[c];
                end
            end
        end
        for (int c = 0; c < 3; c++) begin
            center_model[c] = 8'(center_sum[c] / (CENTER_WINDOW * CENTER_WINDOW));
            average_model[c] = 8'(average_sum[c] / (AVERAGE_WINDOW * AVERAGE_WINDOW));
        end
    endtask

    task automatic drive_frame();
        for (int lead = 0; lead < FRAME_LEAD; lead++) begin
            @(posedge mipi_byte_clock);
            frame_valid <= 1'b1;
        end
        for (int y = 0; y < RAW_HEIGHT; y++) begin
            for (int x = 0; x < RAW_WIDTH; x++) begin
                @(posedge mipi_byte_clock);
                line_valid <= 1'b1;
                bayer_data <= frame_pixels[y][x];
            end
            for (int gap = 0; gap < LINE_GAP; gap++) begin
                @(posedge mipi_byte_clock);
                line_valid <= 1'b0;
                bayer_data <= '0;
            end
        end
        @(posedge mipi_byte_clock);
        frame_valid <= 1'b0;
    endtask

    task automatic read_opcode(input logic [7:0] op, input logic [7:0] expected);
        @(posedge mipi_byte_clock);
        op_code <= op;
        op_code_valid <= 1'b1;
        requests++;
        @(posedge mipi_byte_clock);
        op_code_valid <= 1'b0;
        @(negedge mipi_byte_clock);
        checks++;
        if (!response_valid) begin
            errors++;
            $display("No response pulse one cycle after opcode 0x%02h at %0t ns", op, $time);
        end else if (response !== expected) begin
            errors++;
            $display("error at %0t ns: opcode 0x%02h read %0d, expected %0d",
                     $time, op, response, expected);
        end
        @(negedge mipi_byte_clock);
        if (response_valid) begin
            errors++;
            $display("Response pulse for opcode 0x%02h lasted more than one cycle", op);
        end
    endtask

    initial begin
        logic [7:0] op;
        mipi_byte_clock = 1'b0;
        mipi_byte_reset_n = 1'b0;
        bayer_data = '0;
        line_valid = 1'b0;
        frame_valid = 1'b0;
        op_code = '0;
        op_code_valid = 1'b0;
        lcg_state = 32'd73936;
        frames_done = 0;
        requests = 0;
        pulses = 0;
        checks = 0;
        errors = 0;
        for (int c = 0; c < 3; c++) begin
            center_model[c] = 8'd0;
            average_model[c] = 8'd0;
        end

        tests[0] = '{1'b0, 10'd400, 10'd600, 10'd800, 10'd0, 4'd8, ALL_READS};
        tests[1] = '{1'b1, 10'd0, 10'd0, 10'd0, 10'd0, 4'd6, RESULT_READS};
        tests[2] = '{1'b0, 10'd100, 10'd520, 10'd1000, 10'd1023, 4'd8, ALL_READS};
        tests[3] = '{1'b1, 10'd0, 10'd0, 10'd0, 10'd0, 4'd8, ALL_READS};
        tests[4] = '{1'b0, 10'd3, 10'd5, 10'd7, 10'd1023, 4'd8, ODD_READS};

        repeat (10) @(posedge mipi_byte_clock);
        mipi_byte_reset_n <= 1'b1;

        for (int k = 0; k < 8; k++)
            read_opcode(ALL_READS[8 * k +: 8], 8'd0); // Everything clear after reset

        for (int t = 0; t < NUM_ENTRIES; t++) begin
            build_frame(tests[t]);
            compute_model();
            drive_frame();
            repeat (4) @(posedge mipi_byte_clock);
            frames_done++;
            for (int k = 0; k < int'(tests[t].op_count); k++) begin
                op = tests[t].ops[8 * k +: 8];
                read_opcode(op, expected_response(op));
            end
        end

        @(posedge mipi_byte_clock);
        checks++;
        if (pulses != requests) begin
            errors++;
            $display("Saw %0d response cycles for %0d requests", pulses, requests);
        end

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge mipi_byte_clock);
        $display("Watchdog expired before all table entries finished");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
source/camera_pkg.sv
source/bayer_crop.sv
source/debayer.sv
source/metering.sv
source/metering_registers.sv
source/camera_pipeline.sv
dv/camera_pipeline_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the camera pipeline regression with Verilator.
# Pass or fail comes from the simulation log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module camera_pipeline_tb \
    -f filelist.f -o camera_pipeline_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/camera_pipeline_sim > sim.log 2>&1
cat sim.log

grep -q "Regression passed" sim.log && exit 0 \
    || { echo "Pass message not found in sim.log"; exit 1; }
